// ==== Makefile ====
TOP := load_miss_queue_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing -j 0 -f load_miss_queue.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Finished with no errors"

lint:
	verilator --lint-only --timing -f load_miss_queue.f --top-module load_miss_queue

clean:
	rm -rf obj_dir

// ==== load_miss_queue.f ====
+incdir+rtl
rtl/l2_bus_pkg.sv
rtl/miss_queue_pkg.sv
rtl/miss_entry_table.sv
rtl/issue_arbiter.sv
rtl/issue_control_fsm.sv
rtl/load_miss_queue.sv
verif/tb_clock_gen.sv
verif/load_miss_queue_tb.sv

// ==== rtl/issue_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lmq_settings.svh"

module issue_arbiter
(
	input  logic clk,
	input  logic rst_n_i,
	input  logic [`LMQ_ENTRIES-1:0] pending_mask_i,
	input  logic issue_take_i,
	output logic grant_valid_o,
	output miss_queue_pkg::entry_idx_t grant_entry_o
);

	import miss_queue_pkg::*;

	// Highest priority index
	entry_idx_t ptr_q;
	entry_idx_t cand;
	entry_idx_t next_ptr;

	// Scan from the far end so the nearest pending index above the pointer wins
	always_comb
	begin
		grant_valid_o = 1'b0;
		grant_entry_o = '0;
		cand = '0;
		for (int k = `LMQ_ENTRIES - 1; k >= 0; k--)
		begin
			cand = entry_idx_t'((int'(ptr_q) + k) % `LMQ_ENTRIES);
			if (pending_mask_i[cand])
			begin
				grant_valid_o = 1'b1;
				grant_entry_o = cand;
			end
		end
	end

	// Granted entry drops to lowest priority
	assign next_ptr = entry_idx_t'((int'(grant_entry_o) + 1) % `LMQ_ENTRIES);

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			ptr_q <= '0;
		else if (issue_take_i)
			ptr_q <= next_ptr;
	end

endmodule

`default_nettype wire

// ==== rtl/issue_control_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module issue_control_fsm
(
	input  logic clk,
	input  logic rst_n_i,
	input  logic grant_valid_i,
	input  miss_queue_pkg::entry_idx_t grant_entry_i,
	input  miss_queue_pkg::lmq_entry_t issue_view_i,
	input  logic l2_ack_i,
	output logic issue_take_o,
	output miss_queue_pkg::entry_idx_t issue_entry_o,
	output logic mark_issued_o,
	output logic l2_req_valid_o,
	output l2_bus_pkg::l2_req_t l2_req_o
);

	import miss_queue_pkg::*;
	import l2_bus_pkg::*;

	typedef enum logic
	{
		IDLE,
		WAIT_ACK
	} state_e;

	state_e state_q;
	state_e state_d;
	entry_idx_t entry_q;

	// Take the grant only while no request is outstanding
	assign issue_take_o = state_q == IDLE && grant_valid_i;
	assign mark_issued_o = state_q == WAIT_ACK && l2_ack_i;
	assign l2_req_valid_o = state_q == WAIT_ACK;
	assign issue_entry_o = entry_q;

	// Entry fields stay put while it is outstanding, so the bus is stable
	assign l2_req_o = '{
		id: '{id_class: LOAD_QUEUE, entry: entry_q},
		op: L2_OP_LOAD,
		way: issue_view_i.way,
		address: {issue_view_i.tag, issue_view_i.set_idx}
	};

	always_comb
	begin
		state_d = state_q;
		case (state_q)
			IDLE:
			begin
				if (grant_valid_i)
					state_d = WAIT_ACK;
			end

			WAIT_ACK:
			begin
				// One idle cycle follows every ack
				if (l2_ack_i)
					state_d = IDLE;
			end

			default:
				state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
			state_q <= IDLE;
		else
			state_q <= state_d;
	end

	always_ff @(posedge clk)
	begin
		if (issue_take_o)
			entry_q <= grant_entry_i;
	end

endmodule

`default_nettype wire

// ==== rtl/l2_bus_pkg.sv ====
`default_nettype none

`include "lmq_settings.svh"

package l2_bus_pkg;

	localparam int L2_ADDR_WIDTH = `LMQ_TAG_WIDTH + `LMQ_SET_WIDTH;

	// Only loads leave this unit
	typedef enum logic [1:0]
	{
		L2_OP_LOAD = 2'd0
	} l2_op_e;

	// Upper id bits tell the L2 which requester owns the transaction
	typedef enum logic [1:0]
	{
		LOAD_QUEUE = 2'd1
	} l2_id_class_e;

	typedef struct packed
	{
		l2_id_class_e id_class;
		logic [1:0] entry;
	} l2_id_t;

	typedef struct packed
	{
		l2_id_t id;
		l2_op_e op;
		logic [1:0] way;
		logic [L2_ADDR_WIDTH-1:0] address;
	} l2_req_t;

	typedef struct packed
	{
		logic valid;
		l2_id_t id;
		l2_op_e op;
	} l2_resp_t;

endpackage

`default_nettype wire

// ==== rtl/lmq_settings.svh ====
`ifndef LMQ_SETTINGS_SVH
`define LMQ_SETTINGS_SVH

// Line address split into tag and set index
`define LMQ_TAG_WIDTH 21
`define LMQ_SET_WIDTH 5

// Outstanding misses the queue can track
`define LMQ_ENTRIES 4

// Hardware strands sharing the data cache
`define LMQ_STRANDS 4

`endif

// ==== rtl/load_miss_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lmq_settings.svh"

module load_miss_queue
(
	input  logic clk,
	input  logic rst_n_i,
	input  logic request_i,
	input  miss_queue_pkg::miss_req_t miss_i,
	output logic queue_full_o,
	output logic l2_req_valid_o,
	output l2_bus_pkg::l2_req_t l2_req_o,
	input  logic l2_ack_i,
	input  l2_bus_pkg::l2_resp_t l2_resp_i,
	output miss_queue_pkg::load_complete_t load_complete_o,
	output logic load_complete_valid_o
);

	import miss_queue_pkg::*;

	logic [`LMQ_ENTRIES-1:0] pending_mask;
	logic grant_valid;
	entry_idx_t grant_entry;
	logic issue_take;
	logic mark_issued;
	entry_idx_t issue_entry;
	lmq_entry_t issue_view;

	miss_entry_table u_table
	(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.request_i(request_i),
		.miss_i(miss_i),
		.mark_issued_i(mark_issued),
		.issue_entry_i(issue_entry),
		.resp_i(l2_resp_i),
		.pending_mask_o(pending_mask),
		.issue_view_o(issue_view),
		.queue_full_o(queue_full_o),
		.load_complete_o(load_complete_o),
		.load_complete_valid_o(load_complete_valid_o)
	);

	issue_arbiter u_arbiter
	(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.pending_mask_i(pending_mask),
		.issue_take_i(issue_take),
		.grant_valid_o(grant_valid),
		.grant_entry_o(grant_entry)
	);

	issue_control_fsm u_issue_fsm
	(
		.clk(clk),
		.rst_n_i(rst_n_i),
		.grant_valid_i(grant_valid),
		.grant_entry_i(grant_entry),
		.issue_view_i(issue_view),
		.l2_ack_i(l2_ack_i),
		.issue_take_o(issue_take),
		.issue_entry_o(issue_entry),
		.mark_issued_o(mark_issued),
		.l2_req_valid_o(l2_req_valid_o),
		.l2_req_o(l2_req_o)
	);

endmodule

`default_nettype wire

// ==== rtl/miss_entry_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lmq_settings.svh"

module miss_entry_table
(
	input  logic clk,
	input  logic rst_n_i,
	input  logic request_i,
	input  miss_queue_pkg::miss_req_t miss_i,
	input  logic mark_issued_i,
	input  miss_queue_pkg::entry_idx_t issue_entry_i,
	input  l2_bus_pkg::l2_resp_t resp_i,
	output logic [`LMQ_ENTRIES-1:0] pending_mask_o,
	output miss_queue_pkg::lmq_entry_t issue_view_o,
	output logic queue_full_o,
	output miss_queue_pkg::load_complete_t load_complete_o,
	output logic load_complete_valid_o
);

	import miss_queue_pkg::*;
	import l2_bus_pkg::*;

	// Per-entry control bits
	logic [`LMQ_ENTRIES-1:0] valid_q;
	logic [`LMQ_ENTRIES-1:0] issued_q;

	// Per-entry payload
	tag_t tag_q [`LMQ_ENTRIES];
	set_idx_t set_q [`LMQ_ENTRIES];
	way_t way_q [`LMQ_ENTRIES];
	strand_mask_t strands_q [`LMQ_ENTRIES];

	logic hit;
	entry_idx_t hit_idx;
	entry_idx_t free_idx;
	logic alloc;
	logic merge;
	strand_mask_t strand_bit;
	entry_idx_t resp_entry;
	logic resp_hit;

	// Response lookup where the low id bits select the entry
	assign resp_entry = resp_i.id.entry;
	assign resp_hit = resp_i.valid && resp_i.id.id_class == LOAD_QUEUE
		&& valid_q[resp_entry];

	// Collision CAM that skips an entry retiring this cycle
	always_comb
	begin
		hit = 1'b0;
		hit_idx = '0;
		for (int i = 0; i < `LMQ_ENTRIES; i++)
		begin
			if (valid_q[i] && !(resp_hit && resp_entry == entry_idx_t'(i))
				&& tag_q[i] == miss_i.tag && set_q[i] == miss_i.set_idx)
			begin
				hit = 1'b1;
				hit_idx = entry_idx_t'(i);
			end
		end
	end

	// Lowest free entry wins
	always_comb
	begin
		free_idx = '0;
		for (int i = `LMQ_ENTRIES - 1; i >= 0; i--)
		begin
			if (!valid_q[i])
				free_idx = entry_idx_t'(i);
		end
	end

	assign queue_full_o = &valid_q;
	assign merge = request_i && hit;
	assign alloc = request_i && !hit && !queue_full_o;
	assign strand_bit = strand_mask_t'(1) << miss_i.strand;
	assign pending_mask_o = valid_q & ~issued_q;

	assign issue_view_o = '{
		tag: tag_q[issue_entry_i],
		set_idx: set_q[issue_entry_i],
		way: way_q[issue_entry_i],
		strands: strands_q[issue_entry_i],
		valid: valid_q[issue_entry_i],
		issued: issued_q[issue_entry_i]
	};

	// Completion report follows the response in the same cycle
	assign load_complete_valid_o = resp_hit;
	assign load_complete_o = resp_hit ? load_complete_t'{
		strands: strands_q[resp_entry],
		tag: tag_q[resp_entry],
		set_idx: set_q[resp_entry],
		way: way_q[resp_entry]
	} : '0;

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			valid_q <= '0;
			issued_q <= '0;
		end
		else
		begin
			if (alloc)
			begin
				valid_q[free_idx] <= 1'b1;
				issued_q[free_idx] <= 1'b0;
			end

			if (mark_issued_i)
				issued_q[issue_entry_i] <= 1'b1;

			if (resp_hit)
			begin
				valid_q[resp_entry] <= 1'b0;
				issued_q[resp_entry] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (alloc)
		begin
			tag_q[free_idx] <= miss_i.tag;
			set_q[free_idx] <= miss_i.set_idx;
			way_q[free_idx] <= miss_i.way;
			strands_q[free_idx] <= strand_bit;
		end
		else if (merge)
			strands_q[hit_idx] <= strands_q[hit_idx] | strand_bit;
	end

endmodule

`default_nettype wire

// ==== rtl/miss_queue_pkg.sv ====
`default_nettype none

`include "lmq_settings.svh"

package miss_queue_pkg;

	localparam int ENTRY_IDX_WIDTH = $clog2(`LMQ_ENTRIES);
	localparam int STRAND_IDX_WIDTH = $clog2(`LMQ_STRANDS);

	typedef logic [ENTRY_IDX_WIDTH-1:0] entry_idx_t;
	typedef logic [1:0] way_t;
	typedef logic [`LMQ_STRANDS-1:0] strand_mask_t;
	typedef logic [`LMQ_TAG_WIDTH-1:0] tag_t;
	typedef logic [`LMQ_SET_WIDTH-1:0] set_idx_t;

	// Miss presented by the cache pipeline
	typedef struct packed
	{
		tag_t tag;
		set_idx_t set_idx;
		way_t way;
		logic [STRAND_IDX_WIDTH-1:0] strand;
	} miss_req_t;

	typedef struct packed
	{
		tag_t tag;
		set_idx_t set_idx;
		way_t way;
		strand_mask_t strands;
		logic valid;
		logic issued;
	} lmq_entry_t;

	// All zero when no load completes
	typedef struct packed
	{
		strand_mask_t strands;
		tag_t tag;
		set_idx_t set_idx;
		way_t way;
	} load_complete_t;

endpackage

`default_nettype wire

// ==== verif/load_miss_queue_patterns.txt ====
# All fields hex. REQ tag set way strand | ISSUE entry address way
# RESP id strands tag set way, id is class above entry | FULL level
# Single miss takes entry 0
REQ 1a2b3 05 2 0
ISSUE 0 345665 2
RESP 4 1 1a2b3 05 2
FULL 0
# Second strand merges, one issue, both strands complete
REQ 00abc 1f 1 2
REQ 00abc 1f 3 3
ISSUE 0 01579f 1
RESP 4 c 00abc 1f 1
RESP 4 0 0 0 0
# Round robin with the pointer past entry 0, wrong class ignored
REQ 10000 01 0 1
ISSUE 0 200001 0
REQ 0ffff 02 3 0
RESP 8 0 0 0 0
RESP 4 2 10000 01 0
REQ 12345 10 1 2
REQ 1ffff 1e 2 3
RESP c 0 0 0 0
ISSUE 1 1fffe2 3
ISSUE 2 3ffffe 2
ISSUE 0 2468b0 1
RESP 5 1 0ffff 02 3
RESP 6 8 1ffff 1e 2
RESP 4 4 12345 10 1
FULL 0
# Fill all four, drop a new line, merge still allowed
REQ 00001 00 0 0
REQ 00002 03 1 1
REQ 0abcd 0a 2 2
REQ 1fffff 1f 3 3
FULL 1
REQ 05555 15 0 0
FULL 1
REQ 00002 03 2 3
ISSUE 0 000020 0
ISSUE 1 000043 1
ISSUE 2 1579aa 2
ISSUE 3 3ffffff 3
RESP 6 4 0abcd 0a 2
FULL 0
# Freed entry is reused
REQ 0dead 0d 1 1
ISSUE 2 1bd5ad 1
RESP 4 1 00001 00 0
RESP 5 a 00002 03 1
RESP 6 2 0dead 0d 1
RESP 7 8 1fffff 1f 3
RESP 7 0 0 0 0
FULL 0

// ==== verif/load_miss_queue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "lmq_settings.svh"

module load_miss_queue_tb;

	import miss_queue_pkg::*;
	import l2_bus_pkg::*;

	localparam int CYCLES_PER_LINE = 40;
	localparam string PATTERN_FILE = "verif/load_miss_queue_patterns.txt";

	// Expected L2 request taken from one ISSUE line
	typedef struct packed
	{
		logic [15:0] step;
		logic [1:0] entry;
		logic [L2_ADDR_WIDTH-1:0] address;
		logic [1:0] way;
	} issue_exp_t;

	logic clk;
	logic rst_n;
	logic request_i;
	miss_req_t miss_i;
	logic queue_full_o;
	logic l2_req_valid_o;
	l2_req_t l2_req_o;
	logic l2_ack_i;
	l2_resp_t l2_resp_i;
	load_complete_t load_complete_o;
	logic load_complete_valid_o;

	issue_exp_t issue_q [$];
	logic l2_busy;
	logic [7:0] lfsr_state;
	int total_lines;

	tb_clock_gen u_clock_gen
	(
		.clk_o(clk),
		.rst_n_o(rst_n)
	);

	load_miss_queue uut
	(
		.clk(clk),
		.rst_n_i(rst_n),
		.request_i(request_i),
		.miss_i(miss_i),
		.queue_full_o(queue_full_o),
		.l2_req_valid_o(l2_req_valid_o),
		.l2_req_o(l2_req_o),
		.l2_ack_i(l2_ack_i),
		.l2_resp_i(l2_resp_i),
		.load_complete_o(load_complete_o),
		.load_complete_valid_o(load_complete_valid_o)
	);

	task automatic compare_value(input string name, input logic [63:0] expected,
		input logic [63:0] actual);
		if (expected !== actual)
		begin
			$display("MISMATCH %s expected %0h actual %0h", name, expected, actual);
			$display("Finished with errors");
			$fatal(1);
		end
	endtask

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Finished with errors");
		$fatal(1);
	endtask

	// 8-bit Fibonacci LFSR with taps 8 6 5 4
	function automatic logic next_random_bit();
		lfsr_state = {lfsr_state[6:0],
			lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3]};
		return lfsr_state[0];
	endfunction

	// One-cycle strobe sampled at the second edge
	task automatic drive_request(input logic [`LMQ_TAG_WIDTH-1:0] tag,
		input logic [`LMQ_SET_WIDTH-1:0] set_idx, input logic [1:0] way,
		input logic [1:0] strand);
		@(posedge clk);
		request_i <= 1'b1;
		miss_i <= {tag, set_idx, way, strand};
		@(posedge clk);
		request_i <= 1'b0;
	endtask

	task automatic wait_l2_drained();
		while (issue_q.size() != 0 || l2_busy)
			@(posedge clk);
	endtask

	// Completion is combinational, so look at it mid-cycle
	task automatic send_response(input int step, input logic [3:0] id,
		input logic [3:0] strands, input logic [`LMQ_TAG_WIDTH-1:0] tag,
		input logic [`LMQ_SET_WIDTH-1:0] set_idx, input logic [1:0] way);
		wait_l2_drained();
		@(posedge clk);
		l2_resp_i <= {1'b1, id, 2'b00};
		@(negedge clk);
		compare_value($sformatf("step %0d complete valid", step), strands != 4'd0,
			load_complete_valid_o);
		compare_value($sformatf("step %0d complete strands", step), strands,
			load_complete_o.strands);
		compare_value($sformatf("step %0d complete tag", step), tag, load_complete_o.tag);
		compare_value($sformatf("step %0d complete set", step), set_idx,
			load_complete_o.set_idx);
		compare_value($sformatf("step %0d complete way", step), way, load_complete_o.way);
		@(posedge clk);
		l2_resp_i <= '0;
	endtask

	// L2 model that acks each request after 0 to 3 cycles
	initial
	begin : l2_model
		issue_exp_t want;
		l2_req_t held;
		logic b0;
		logic b1;
		string name;

		l2_ack_i = 1'b0;
		l2_busy = 1'b0;
		lfsr_state = 8'd93;
		forever
		begin
			@(negedge clk);
			if (l2_req_valid_o && issue_q.size() > 0)
			begin
				l2_busy = 1'b1;
				want = issue_q.pop_front();
				held = l2_req_o;
				name = $sformatf("step %0d issue", want.step);
				// LOAD_QUEUE class sits above the entry index
				compare_value({name, " id"}, {2'b01, want.entry}, l2_req_o.id);
				compare_value({name, " op"}, 2'd0, l2_req_o.op);
				compare_value({name, " address"}, want.address, l2_req_o.address);
				compare_value({name, " way"}, want.way, l2_req_o.way);
				b0 = next_random_bit();
				b1 = next_random_bit();
				repeat ({b1, b0})
				begin
					@(negedge clk);
					compare_value({name, " held"}, 1'b1, l2_req_valid_o);
					compare_value({name, " stable"}, held, l2_req_o);
				end
				@(posedge clk);
				l2_ack_i <= 1'b1;
				@(negedge clk);
				compare_value({name, " held at ack"}, 1'b1, l2_req_valid_o);
				compare_value({name, " stable at ack"}, held, l2_req_o);
				@(posedge clk);
				l2_ack_i <= 1'b0;
				@(negedge clk);
				compare_value({name, " drop after ack"}, 1'b0, l2_req_valid_o);
				l2_busy = 1'b0;
			end
		end
	end

	initial
	begin : watchdog
		wait (total_lines > 0);
		repeat (total_lines * CYCLES_PER_LINE) @(posedge clk);
		$display("Timeout after %0d cycles, the patterns did not complete",
			total_lines * CYCLES_PER_LINE);
		$display("Finished with errors");
		$fatal(1);
	end

	initial
	begin : run_patterns
		int fd;
		int step;
		int n;
		logic [63:0] cmd;
		logic [1023:0] line_buf;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [31:0] f4;

		request_i = 1'b0;
		miss_i = '0;
		l2_resp_i = '0;
		step = 0;
		total_lines = 0;

		// Line count sets the watchdog budget
		fd = $fopen(PATTERN_FILE, "r");
		if (fd == 0)
			abort_run("Cannot open the pattern file");
		while ($fgets(line_buf, fd) > 0)
			total_lines++;
		$fclose(fd);
		fd = $fopen(PATTERN_FILE, "r");

		wait (rst_n === 1'b1);
		@(negedge clk);
		compare_value("reset request valid", 1'b0, l2_req_valid_o);
		compare_value("reset queue full", 1'b0, queue_full_o);
		compare_value("reset complete valid", 1'b0, load_complete_valid_o);

		while ($fscanf(fd, "%s", cmd) == 1)
		begin
			if (cmd == "#")
				n = $fgets(line_buf, fd);
			else
			begin
				step++;
				if (cmd == "REQ")
				begin
					n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
					if (n != 4)
						abort_run($sformatf("Step %0d has a malformed REQ line", step));
					drive_request(f0[`LMQ_TAG_WIDTH-1:0], f1[`LMQ_SET_WIDTH-1:0],
						f2[1:0], f3[1:0]);
				end
				else if (cmd == "ISSUE")
				begin
					n = $fscanf(fd, "%h %h %h", f0, f1, f2);
					if (n != 3)
						abort_run($sformatf("Step %0d has a malformed ISSUE line", step));
					issue_q.push_back({16'(step), f0[1:0], f1[L2_ADDR_WIDTH-1:0], f2[1:0]});
				end
				else if (cmd == "RESP")
				begin
					n = $fscanf(fd, "%h %h %h %h %h", f0, f1, f2, f3, f4);
					if (n != 5)
						abort_run($sformatf("Step %0d has a malformed RESP line", step));
					send_response(step, f0[3:0], f1[3:0], f2[`LMQ_TAG_WIDTH-1:0],
						f3[`LMQ_SET_WIDTH-1:0], f4[1:0]);
				end
				else if (cmd == "FULL")
				begin
					n = $fscanf(fd, "%h", f0);
					if (n != 1)
						abort_run($sformatf("Step %0d has a malformed FULL line", step));
					@(negedge clk);
					compare_value($sformatf("step %0d queue full", step), f0[0], queue_full_o);
				end
				else
					abort_run($sformatf("Step %0d has an unknown command", step));
			end
		end
		$fclose(fd);

		// A duplicate issue would show up here
		wait_l2_drained();
		repeat (4) @(posedge clk);
		@(negedge clk);
		compare_value("idle bus at end", 1'b0, l2_req_valid_o);
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen
#(
	parameter int PERIOD_NS = 10,
	parameter int RESET_CYCLES = 3
)
(
	output logic clk_o,
	output logic rst_n_o
);

	initial
	begin
		clk_o = 1'b0;
		forever
			#(PERIOD_NS / 2) clk_o = ~clk_o;
	end

	// Release on a falling edge, away from the sampling edge
	initial
	begin
		rst_n_o = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_o);
		@(negedge clk_o);
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire
